/* verilog/mips_pkg.sv */
package mips_pkg;

  // major opcodes, instruction bits 31:26.
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_ADDI  = 6'h08;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_LUI   = 6'h0f;
  localparam logic [5:0] OP_ORI   = 6'h0d;
  localparam logic [5:0] OP_XORI  = 6'h0e;
  localparam logic [5:0] OP_ANDI  = 6'h0c;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_J     = 6'h02;

  localparam int ALU_CTRL_W = 6;

  // R-type function codes double as ALU codes.
  localparam logic [ALU_CTRL_W-1:0] F_ADD   = 6'b100000;
  localparam logic [ALU_CTRL_W-1:0] F_ADDU  = 6'b100001;
  localparam logic [ALU_CTRL_W-1:0] F_SUB   = 6'b100010;
  localparam logic [ALU_CTRL_W-1:0] F_SUBU  = 6'b100011;
  localparam logic [ALU_CTRL_W-1:0] F_AND   = 6'b100100;
  localparam logic [ALU_CTRL_W-1:0] F_OR    = 6'b100101;
  localparam logic [ALU_CTRL_W-1:0] F_XOR   = 6'b100110;
  localparam logic [ALU_CTRL_W-1:0] F_NOR   = 6'b100111;
  localparam logic [ALU_CTRL_W-1:0] F_SLT   = 6'b101010;
  localparam logic [ALU_CTRL_W-1:0] F_SLTU  = 6'b101011;
  localparam logic [ALU_CTRL_W-1:0] F_SLL   = 6'b000000;
  localparam logic [ALU_CTRL_W-1:0] F_SRL   = 6'b000010;
  localparam logic [ALU_CTRL_W-1:0] F_SRA   = 6'b000011;
  localparam logic [ALU_CTRL_W-1:0] F_SLLV  = 6'b000100;
  localparam logic [ALU_CTRL_W-1:0] F_SRLV  = 6'b000110;
  localparam logic [ALU_CTRL_W-1:0] F_SRAV  = 6'b000111;
  localparam logic [ALU_CTRL_W-1:0] F_JR    = 6'b001000;

  // these ALU codes have no function code behind them.
  localparam logic [ALU_CTRL_W-1:0] F_LUI   = 6'b111100;
  localparam logic [ALU_CTRL_W-1:0] F_ROTR  = 6'b111110;
  localparam logic [ALU_CTRL_W-1:0] F_ROTRV = 6'b111111;

  // word addresses; registers sit at 0 to 31.
  localparam logic [5:0] ADR_INSTR  = 6'h20;
  localparam logic [5:0] ADR_STATUS = 6'h21;

  localparam int ST_ZERO    = 0;
  localparam int ST_JR      = 1;
  localparam int ST_ILLEGAL = 2;

endpackage

/* verilog/alu_control.sv */
`timescale 1ns/100ps

module alu_control
  import mips_pkg::*;
(
  input  logic [5:0]            i_alu_op,
  input  logic [5:0]            i_func,
  input  logic                  i_r_field,
  output logic [ALU_CTRL_W-1:0] o_alu_ctrl,
  output logic                  o_shamt_src,
  output logic                  o_jr,
  output logic                  o_legal
);

  always_comb
  begin
    o_alu_ctrl  = '0;
    o_shamt_src = 1'b0;
    o_jr        = 1'b0;
    o_legal     = 1'b1;
    case (i_alu_op)
      OP_ADDI, OP_ADDIU, OP_LW, OP_SW:
        o_alu_ctrl = F_ADD;
      OP_BEQ, OP_BNE:
        o_alu_ctrl = F_SUB;
      OP_ORI:
        o_alu_ctrl = F_OR;
      OP_XORI:
        o_alu_ctrl = F_XOR;
      OP_ANDI:
        o_alu_ctrl = F_AND;
      OP_LUI:
        o_alu_ctrl = F_LUI;
      OP_RTYPE:
      begin
        case (i_func)
          F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND, F_OR, F_XOR, F_NOR,
          F_SLT, F_SLTU, F_SLLV, F_SRAV:
            o_alu_ctrl = i_func;
          F_SRLV:
            o_alu_ctrl = i_r_field ? F_ROTRV : i_func;
          F_SLL, F_SRA:
          begin
            o_alu_ctrl  = i_func;
            o_shamt_src = 1'b1;
          end
          F_SRL:
          begin
            // the rotate bit turns a logical shift right into rotr.
            o_alu_ctrl  = i_r_field ? F_ROTR : i_func;
            o_shamt_src = 1'b1;
          end
          F_JR:
          begin
            o_alu_ctrl = i_func;
            o_jr       = 1'b1;
          end
          default:
            o_legal = 1'b0;
        endcase
      end
      // j and anything unlisted land here.
      default:
        o_legal = 1'b0;
    endcase
  end

endmodule

/* verilog/instr_decode.sv */
`timescale 1ns/100ps

module instr_decode
  import mips_pkg::*;
(
  input  logic [31:0] i_instr,
  output logic [5:0]  o_opcode,
  output logic [5:0]  o_func,
  output logic        o_r_field,
  output logic [4:0]  o_rs,
  output logic [4:0]  o_rt,
  output logic [4:0]  o_shamt,
  output logic [31:0] o_imm,
  output logic        o_use_imm,
  output logic [4:0]  o_wr_addr,
  output logic        o_wr_req
);

  logic        is_rtype;
  logic        is_logic_imm;
  logic        is_wb_imm;
  logic [15:0] imm16;

  assign o_opcode = i_instr[31:26];
  assign o_func   = i_instr[5:0];
  assign o_rs     = i_instr[25:21];
  assign o_rt     = i_instr[20:16];
  assign o_shamt  = i_instr[10:6];
  assign imm16    = i_instr[15:0];

  // rotr keeps the flag in the unused rs field, rotrv in the unused shamt field.
  assign o_r_field = (o_func == F_SRL) ? i_instr[21] : i_instr[6];

  assign is_rtype     = (o_opcode == OP_RTYPE);
  assign is_logic_imm = (o_opcode == OP_ANDI) || (o_opcode == OP_ORI) ||
                        (o_opcode == OP_XORI);
  assign is_wb_imm    = is_logic_imm || (o_opcode == OP_ADDI) ||
                        (o_opcode == OP_ADDIU) || (o_opcode == OP_LUI);

  always_comb
  begin
    if (is_logic_imm)
      o_imm = {16'h0000, imm16};
    else
      o_imm = {{16{imm16[15]}}, imm16};
  end

  // branches compare rs against rt, so they keep rt as operand b.
  assign o_use_imm = is_wb_imm || (o_opcode == OP_LW) || (o_opcode == OP_SW);

  assign o_wr_addr = is_rtype ? i_instr[15:11] : o_rt;
  assign o_wr_req  = is_rtype || is_wb_imm;

endmodule

/* verilog/alu.sv */
`timescale 1ns/100ps

module alu
  import mips_pkg::*;
(
  input  logic [ALU_CTRL_W-1:0] i_alu_ctrl,
  input  logic [31:0]           i_rs_val,
  input  logic [31:0]           i_rt_val,
  input  logic [31:0]           i_imm,
  input  logic                  i_use_imm,
  input  logic [4:0]            i_shamt,
  input  logic                  i_shamt_src,
  output logic [31:0]           o_result,
  output logic                  o_zero
);

  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [4:0]  shift_amt;
  logic [63:0] rot_full;

  assign op_a      = i_rs_val;
  assign op_b      = i_use_imm ? i_imm : i_rt_val;
  assign shift_amt = i_shamt_src ? i_shamt : i_rs_val[4:0];

  // rotating right is a right shift of the doubled word.
  assign rot_full = {i_rt_val, i_rt_val} >> shift_amt;

  always_comb
  begin
    case (i_alu_ctrl)
      F_ADD, F_ADDU:
        o_result = op_a + op_b;
      F_SUB, F_SUBU:
        o_result = op_a - op_b;
      F_AND:
        o_result = op_a & op_b;
      F_OR:
        o_result = op_a | op_b;
      F_XOR:
        o_result = op_a ^ op_b;
      F_NOR:
        o_result = ~(op_a | op_b);
      F_SLT:
        o_result = {31'd0, $signed(op_a) < $signed(op_b)};
      F_SLTU:
        o_result = {31'd0, op_a < op_b};
      F_SLL, F_SLLV:
        o_result = i_rt_val << shift_amt;
      F_SRL, F_SRLV:
        o_result = i_rt_val >> shift_amt;
      F_SRA, F_SRAV:
        o_result = $unsigned($signed(i_rt_val) >>> shift_amt);
      F_ROTR, F_ROTRV:
        o_result = rot_full[31:0];
      F_LUI:
        o_result = {i_imm[15:0], 16'h0000};
      default:
        o_result = 32'h0000_0000;
    endcase
  end

  assign o_zero = (o_result == 32'h0000_0000);

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/100ps

module reg_file
(
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic [4:0]  i_rd_addr_a,
  input  logic [4:0]  i_rd_addr_b,
  output logic [31:0] o_rd_data_a,
  output logic [31:0] o_rd_data_b,
  input  logic        i_we,
  input  logic [4:0]  i_wr_addr,
  input  logic [31:0] i_wr_data
);

  logic [31:0] regs [32];

  // the host expects every register to read back zero after reset.
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= 32'h0000_0000;
    end
    else if (i_we && (i_wr_addr != 5'd0))
    begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  assign o_rd_data_a = (i_rd_addr_a == 5'd0) ? 32'h0000_0000 : regs[i_rd_addr_a];
  assign o_rd_data_b = (i_rd_addr_b == 5'd0) ? 32'h0000_0000 : regs[i_rd_addr_b];

endmodule

/* verilog/exec_bus_ctrl.sv */
`timescale 1ns/100ps

module exec_bus_ctrl
  import mips_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_wb_cyc,
  input  logic        i_wb_stb,
  input  logic        i_wb_we,
  input  logic [5:0]  i_wb_adr,
  input  logic [31:0] i_wb_dat,
  output logic        o_wb_ack,
  output logic [31:0] o_wb_dat,
  output logic [31:0] o_instr,
  input  logic [4:0]  i_rs,
  input  logic        i_wr_req,
  input  logic [4:0]  i_wr_addr,
  input  logic        i_legal,
  input  logic        i_jr,
  input  logic [31:0] i_alu_result,
  input  logic        i_zero,
  output logic        o_rf_we,
  output logic [4:0]  o_rf_wr_addr,
  output logic [31:0] o_rf_wr_data,
  output logic [4:0]  o_rf_rd_addr,
  input  logic [31:0] i_rf_rd_data
);

  logic        access;
  logic        host_reg_wr;
  logic        instr_wr;
  logic [2:0]  status_q;
  logic [31:0] status_word;
  logic [31:0] rd_mux;

  // a new access is one that has not been acknowledged yet.
  assign access      = i_wb_cyc && i_wb_stb && !o_wb_ack;
  assign host_reg_wr = access && i_wb_we && !i_wb_adr[5];
  assign instr_wr    = access && i_wb_we && (i_wb_adr == ADR_INSTR);

  assign o_instr = i_wb_dat;

  // the host write wins the port, an instruction only writes back when it retires cleanly.
  assign o_rf_we      = host_reg_wr || (instr_wr && i_wr_req && i_legal && !i_jr);
  assign o_rf_wr_addr = host_reg_wr ? i_wb_adr[4:0] : i_wr_addr;
  assign o_rf_wr_data = host_reg_wr ? i_wb_dat : i_alu_result;

  assign o_rf_rd_addr = (i_wb_cyc && i_wb_stb && !i_wb_we) ? i_wb_adr[4:0] : i_rs;

  always_comb
  begin
    status_word             = 32'h0000_0000;
    status_word[ST_ZERO]    = status_q[ST_ZERO];
    status_word[ST_JR]      = status_q[ST_JR];
    status_word[ST_ILLEGAL] = status_q[ST_ILLEGAL];
  end

  always_comb
  begin
    if (!i_wb_adr[5])
      rd_mux = i_rf_rd_data;
    else if (i_wb_adr == ADR_STATUS)
      rd_mux = status_word;
    else
      rd_mux = 32'h0000_0000;
  end

  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      o_wb_ack <= 1'b0;
      o_wb_dat <= 32'h0000_0000;
      status_q <= 3'b000;
    end
    else
    begin
      o_wb_ack <= access;
      if (access && !i_wb_we)
        o_wb_dat <= rd_mux;
      if (instr_wr)
      begin
        status_q[ST_ZERO]    <= i_zero;
        status_q[ST_JR]      <= i_jr;
        status_q[ST_ILLEGAL] <= !i_legal;
      end
    end
  end

endmodule

/* verilog/mips_exec.sv */
`timescale 1ns/100ps

module mips_exec
  import mips_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_wb_cyc,
  input  logic        i_wb_stb,
  input  logic        i_wb_we,
  input  logic [5:0]  i_wb_adr,
  input  logic [31:0] i_wb_dat,
  output logic        o_wb_ack,
  output logic [31:0] o_wb_dat
);

  logic [31:0]           instr;
  logic [5:0]            opcode;
  logic [5:0]            func;
  logic                  r_field;
  logic [4:0]            rs;
  logic [4:0]            rt;
  logic [4:0]            shamt;
  logic [31:0]           imm;
  logic                  use_imm;
  logic [4:0]            wr_addr;
  logic                  wr_req;
  logic [ALU_CTRL_W-1:0] alu_ctrl;
  logic                  shamt_src;
  logic                  jr;
  logic                  legal;
  logic [31:0]           alu_result;
  logic                  zero;
  logic                  rf_we;
  logic [4:0]            rf_wr_addr;
  logic [31:0]           rf_wr_data;
  logic [4:0]            rf_rd_addr_a;
  logic [31:0]           rf_rd_data_a;
  logic [31:0]           rf_rd_data_b;

  exec_bus_ctrl u_bus_ctrl (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
    .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .o_wb_ack(o_wb_ack), .o_wb_dat(o_wb_dat),
    .o_instr(instr), .i_rs(rs), .i_wr_req(wr_req), .i_wr_addr(wr_addr),
    .i_legal(legal), .i_jr(jr), .i_alu_result(alu_result), .i_zero(zero),
    .o_rf_we(rf_we), .o_rf_wr_addr(rf_wr_addr), .o_rf_wr_data(rf_wr_data),
    .o_rf_rd_addr(rf_rd_addr_a), .i_rf_rd_data(rf_rd_data_a)
  );

  instr_decode u_decode (
    .i_instr(instr), .o_opcode(opcode), .o_func(func), .o_r_field(r_field),
    .o_rs(rs), .o_rt(rt), .o_shamt(shamt), .o_imm(imm), .o_use_imm(use_imm),
    .o_wr_addr(wr_addr), .o_wr_req(wr_req)
  );

  alu_control u_alu_control (
    .i_alu_op(opcode), .i_func(func), .i_r_field(r_field), .o_alu_ctrl(alu_ctrl),
    .o_shamt_src(shamt_src), .o_jr(jr), .o_legal(legal)
  );

  alu u_alu (
    .i_alu_ctrl(alu_ctrl), .i_rs_val(rf_rd_data_a), .i_rt_val(rf_rd_data_b),
    .i_imm(imm), .i_use_imm(use_imm), .i_shamt(shamt), .i_shamt_src(shamt_src),
    .o_result(alu_result), .o_zero(zero)
  );

  reg_file u_reg_file (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_rd_addr_a(rf_rd_addr_a), .i_rd_addr_b(rt),
    .o_rd_data_a(rf_rd_data_a), .o_rd_data_b(rf_rd_data_b),
    .i_we(rf_we), .i_wr_addr(rf_wr_addr), .i_wr_data(rf_wr_data)
  );

endmodule

/* verification/tb_mips_exec.sv */
`timescale 1ns/100ps

module tb_mips_exec
  import mips_pkg::*;
();

  localparam int ACK_LIMIT = 20;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [5:0]  wb_adr;
  logic [31:0] wb_dat;
  logic        wb_ack;
  logic [31:0] wb_rdat;

  logic [31:0] shadow [32];
  logic [31:0] exp_status;
  logic [31:0] status_mask;
  int          value_errors;
  int          timeouts;
  int          checks;

  mips_exec dut0 (
    .i_clk(clk), .i_rst_n(rst_n), .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
    .i_wb_adr(wb_adr), .i_wb_dat(wb_dat), .o_wb_ack(wb_ack), .o_wb_dat(wb_rdat)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #2 clk = ~clk;
  end

  task automatic finish_run();
    $display("checks %0d, value errors %0d, timeouts %0d", checks, value_errors, timeouts);
    if ((value_errors + timeouts) == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  endtask

  // one classic cycle runs from a falling edge to the falling edge after ack.
  task automatic bus_access(input logic we, input logic [5:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
    int waited;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_dat = wdat;
    waited = 0;
    @(negedge clk);
    while (!wb_ack && waited < ACK_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    rdat   = wb_rdat;
    if (!wb_ack)
    begin
      timeouts++;
      $display("no ack within %0d cycles for address %h at %0t", ACK_LIMIT, adr, $time);
      finish_run();
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      value_errors++;
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_reg(input logic [4:0] n);
    logic [31:0] got;
    bus_access(1'b0, {1'b0, n}, 32'h0, got);
    check_value($sformatf("o_wb_dat (r%0d)", n), got, shadow[n]);
  endtask

  task automatic check_all_regs();
    for (int i = 0; i < 32; i++)
      check_reg(5'(i));
  endtask

  task automatic check_status();
    logic [31:0] got;
    bus_access(1'b0, ADR_STATUS, 32'h0, got);
    check_value("o_wb_dat (status)", got & status_mask, exp_status & status_mask);
  endtask

  task automatic host_write(input logic [4:0] n, input logic [31:0] v);
    logic [31:0] unused_rd;
    bus_access(1'b1, {1'b0, n}, v, unused_rd);
    if (n != 5'd0)
      shadow[n] = v;
  endtask

  function automatic logic [31:0] rotate_right(input logic [31:0] v, input logic [4:0] n);
    return (v >> n) | (v << (6'd32 - {1'b0, n}));
  endfunction

  function automatic logic [31:0] r_instr(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sa,
                                          input logic [5:0] fn);
    return {OP_RTYPE, rs, rt, rd, sa, fn};
  endfunction

  function automatic logic [31:0] i_instr(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'($urandom_range(31));
  endfunction

  // the reference model applies one instruction to the shadow registers.
  task automatic predict(input logic [31:0] instr);
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  sa;
    logic [4:0]  dest;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] res;
    logic        wb;
    logic        jr;
    logic        legal;
    op    = instr[31:26];
    fn    = instr[5:0];
    sa    = instr[10:6];
    a     = shadow[instr[25:21]];
    b     = shadow[instr[20:16]];
    simm  = {{16{instr[15]}}, instr[15:0]};
    dest  = (op == OP_RTYPE) ? instr[15:11] : instr[20:16];
    res   = 32'd0;
    wb    = 1'b1;
    jr    = 1'b0;
    legal = 1'b1;
    case (op)
      OP_RTYPE:
        case (fn)
          F_ADD, F_ADDU: res = a + b;
          F_SUB, F_SUBU: res = a - b;
          F_AND: res = a & b;
          F_OR: res = a | b;
          F_XOR: res = a ^ b;
          F_NOR: res = ~(a | b);
          F_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          F_SLTU: res = (a < b) ? 32'd1 : 32'd0;
          F_SLL: res = b << sa;
          F_SRL: res = instr[21] ? rotate_right(b, sa) : (b >> sa);
          F_SRA: res = $signed(b) >>> sa;
          F_SLLV: res = b << a[4:0];
          F_SRLV: res = instr[6] ? rotate_right(b, a[4:0]) : (b >> a[4:0]);
          F_SRAV: res = $signed(b) >>> a[4:0];
          F_JR:
          begin
            jr = 1'b1;
            wb = 1'b0;
          end
          default: legal = 1'b0;
        endcase
      OP_ADDI, OP_ADDIU: res = a + simm;
      OP_ANDI: res = a & {16'h0000, instr[15:0]};
      OP_ORI: res = a | {16'h0000, instr[15:0]};
      OP_XORI: res = a ^ {16'h0000, instr[15:0]};
      OP_LUI: res = {instr[15:0], 16'h0000};
      OP_LW, OP_SW:
      begin
        res = a + simm;
        wb  = 1'b0;
      end
      OP_BEQ, OP_BNE:
      begin
        res = a - b;
        wb  = 1'b0;
      end
      default: legal = 1'b0;
    endcase
    if (wb && legal && dest != 5'd0)
      shadow[dest] = res;
    exp_status              = 32'd0;
    exp_status[ST_ZERO]     = (res == 32'd0);
    exp_status[ST_JR]       = jr;
    exp_status[ST_ILLEGAL]  = !legal;
    // the zero flag is only defined for an instruction that retires normally.
    status_mask             = 32'hffff_ffff;
    status_mask[ST_ZERO]    = legal && !jr;
  endtask

  task automatic issue(input logic [31:0] instr);
    logic [31:0] unused_rd;
    bus_access(1'b1, ADR_INSTR, instr, unused_rd);
    predict(instr);
    check_status();
    check_reg(instr[15:11]);
    check_reg(instr[20:16]);
  endtask

  initial
  begin
    logic [5:0] arith_fns [10];
    logic [5:0] shift_fns [6];
    logic [5:0] imm_ops [6];
    int         k;
    void'($urandom(32'hbb3cda9e));
    rst_n        = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = 6'd0;
    wb_dat       = 32'd0;
    value_errors = 0;
    timeouts     = 0;
    checks       = 0;
    exp_status   = 32'd0;
    status_mask  = 32'hffff_ffff;
    for (int i = 0; i < 32; i++)
      shadow[i] = 32'd0;
    arith_fns = '{F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND, F_OR, F_XOR, F_NOR, F_SLT, F_SLTU};
    shift_fns = '{F_SLL, F_SRL, F_SRA, F_SLLV, F_SRLV, F_SRAV};
    imm_ops   = '{OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    check_all_regs();
    check_status();
    for (int i = 0; i < 32; i++)
      host_write(5'(i), $urandom);
    check_all_regs();

    // a negative and a small positive operand split slt from sltu.
    host_write(5'd1, 32'hffff_fff0);
    host_write(5'd2, 32'h0000_0010);
    issue(r_instr(5'd1, 5'd2, 5'd3, 5'd0, F_SLT));
    issue(r_instr(5'd1, 5'd2, 5'd3, 5'd0, F_SLTU));
    repeat (40)
    begin
      k = $urandom_range(9);
      issue(r_instr(rand_reg(), rand_reg(), rand_reg(), rand_reg(), arith_fns[k]));
    end
    repeat (30)
    begin
      k = $urandom_range(5);
      issue(i_instr(imm_ops[k], rand_reg(), rand_reg(), 16'($urandom)));
    end

    host_write(5'd4, 32'h8765_4321);
    issue(r_instr(5'd1, 5'd4, 5'd5, 5'd8, F_SRL));
    issue(r_instr(5'd6, 5'd4, 5'd7, 5'd1, F_SRLV));
    repeat (30)
    begin
      k = $urandom_range(5);
      issue(r_instr(rand_reg(), rand_reg(), rand_reg(), rand_reg(), shift_fns[k]));
    end
    check_all_regs();

    issue(i_instr(OP_LW, rand_reg(), rand_reg(), 16'($urandom)));
    issue(i_instr(OP_SW, rand_reg(), rand_reg(), 16'($urandom)));
    issue(i_instr(OP_BNE, 5'd1, 5'd2, 16'h0004));
    issue(i_instr(OP_BEQ, 5'd9, 5'd9, 16'h0004));
    host_write(5'd10, 32'h5a5a_0f0f);
    issue(r_instr(rand_reg(), 5'd0, 5'd10, 5'd0, F_JR));
    issue(r_instr(rand_reg(), rand_reg(), 5'd10, 5'd0, 6'h01));
    issue(i_instr(OP_J, rand_reg(), rand_reg(), 16'($urandom)));
    issue(i_instr(6'h3f, rand_reg(), rand_reg(), 16'($urandom)));
    check_all_regs();
    finish_run();
  end

endmodule

/* mips_exec.f */
verilog/mips_pkg.sv
verilog/alu_control.sv
verilog/instr_decode.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/exec_bus_ctrl.sv
verilog/mips_exec.sv
verification/tb_mips_exec.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failures.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_mips_exec -f mips_exec.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_mips_exec > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "simulation did not run to completion"
  exit 1
fi

cat sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
  echo "result: fail"
  exit 1
fi
echo "result: pass"
exit 0
